// File: src/axi_pkg.sv
package axi_pkg;

  // read channel widths
  localparam int ADDR_W  = 32;
  localparam int DATA_W  = 64;
  localparam int ID_W    = 4;
  localparam int LEN_W   = 8;
  localparam int SIZE_W  = 3;
  localparam int BURST_W = 2;

  // fixed field codes, single beat reads only
  localparam logic [SIZE_W-1:0]  SIZE_4B     = 3'b010;
  localparam logic [BURST_W-1:0] BURST_FIXED = 2'b00;
  localparam logic [LEN_W-1:0]   LEN_SINGLE  = 8'd0;

endpackage

// File: src/rv_inst_pkg.sv
package rv_inst_pkg;

  localparam logic [6:0]  OP_JAL    = 7'b1101111;
  localparam logic [6:0]  OP_BRANCH = 7'b1100011;
  localparam logic [31:0] INST_NOP  = 32'h0000_0013; // addi x0, x0, 0

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } jtype_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } btype_t;

  // same word, two decodings
  typedef union packed {
    jtype_t jtype;
    btype_t btype;
  } inst_t;

  function automatic logic [31:0] imm_j(inst_t inst);
    return {{12{inst.jtype.imm20}}, inst.jtype.imm19_12, inst.jtype.imm11,
            inst.jtype.imm10_1, 1'b0};
  endfunction

  function automatic logic [31:0] imm_b(inst_t inst);
    return {{20{inst.btype.imm12}}, inst.btype.imm11, inst.btype.imm10_5,
            inst.btype.imm4_1, 1'b0};
  endfunction

endpackage

// File: src/axi_if.sv
`timescale 1ns/1ns

interface axi_if;
  import axi_pkg::*;

  // read address channel
  logic               arvalid;
  logic               arready;
  logic [ADDR_W-1:0]  araddr;
  logic [ID_W-1:0]    arid;
  logic [LEN_W-1:0]   arlen;
  logic [SIZE_W-1:0]  arsize;
  logic [BURST_W-1:0] arburst;

  // read data channel
  logic               rvalid;
  logic               rready;
  logic [DATA_W-1:0]  rdata;
  logic               rlast;

  modport master (
    output arvalid, araddr, arid, arlen, arsize, arburst, rready,
    input  arready, rvalid, rdata, rlast
  );

  modport slave (
    input  arvalid, araddr, arid, arlen, arsize, arburst, rready,
    output arready, rvalid, rdata, rlast
  );

endinterface

// File: src/fetch_if.sv
`timescale 1ns/1ns

interface fetch_if;

  logic        valid;
  logic        ready;
  logic [31:0] pc;
  logic [31:0] inst;

  modport source (output valid, pc, inst, input ready);

  modport sink (input valid, pc, inst, output ready);

endinterface

// File: src/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit #(
  parameter logic [axi_pkg::ADDR_W-1:0] reset_pc = 32'h8000_0000
) (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       flush,
  input  logic [axi_pkg::ADDR_W-1:0] dnpc,
  axi_if.master                      mem_r,
  fetch_if.source                    out
);
  import axi_pkg::*;
  import rv_inst_pkg::*;

  typedef enum logic [1:0] {
    ST_REQ,  // address out, waiting for ar handshake
    ST_RESP, // waiting for read data
    ST_HOLD  // instruction held until the queue takes it
  } state_t;

  state_t            state;
  state_t            state_next;
  logic [ADDR_W-1:0] pc;
  logic [ADDR_W-1:0] pc_next;
  logic [31:0]       inst;
  logic [31:0]       inst_next;
  logic              drop_rdata;      // read in flight belongs to a stale pc
  logic              drop_rdata_next;
  logic              ar_fire;
  logic              r_fire;
  logic              out_fire;
  logic [31:0]       rdata_half;

  assign ar_fire    = mem_r.arvalid & mem_r.arready;
  assign r_fire     = mem_r.rvalid & mem_r.rready & mem_r.rlast;
  assign out_fire   = out.valid & out.ready;
  assign rdata_half = pc[2] ? mem_r.rdata[DATA_W-1:32] : mem_r.rdata[31:0];

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= ST_REQ;
      pc         <= reset_pc;
      inst       <= INST_NOP;
      drop_rdata <= 1'b0;
    end else begin
      state      <= state_next;
      pc         <= pc_next;
      inst       <= inst_next;
      drop_rdata <= drop_rdata_next;
    end
  end

  always_comb begin
    state_next      = state;
    pc_next         = pc;
    inst_next       = inst;
    drop_rdata_next = drop_rdata;
    case (state)
      ST_REQ: begin
        if (ar_fire) begin
          state_next = ST_RESP;
          if (flush) begin // too late, read is already out
            drop_rdata_next = 1'b1;
            pc_next         = dnpc;
          end
        end else if (flush) begin
          pc_next = dnpc; // request not taken yet, just retarget
        end
      end
      ST_RESP: begin
        if (r_fire) begin
          if (flush) begin
            state_next      = ST_REQ;
            pc_next         = dnpc;
            drop_rdata_next = 1'b0;
          end else if (drop_rdata) begin
            state_next      = ST_REQ;
            drop_rdata_next = 1'b0;
          end else begin
            state_next = ST_HOLD;
            inst_next  = rdata_half;
          end
        end else if (flush) begin
          drop_rdata_next = 1'b1;
          pc_next         = dnpc;
        end
      end
      ST_HOLD: begin
        if (flush) begin
          state_next = ST_REQ;
          pc_next    = dnpc;
        end else if (out_fire) begin
          state_next = ST_REQ;
          pc_next    = pc + 32'd4;
        end
      end
      default: state_next = ST_REQ;
    endcase
  end

  assign out.valid = (state == ST_HOLD) & ~flush;
  assign out.pc    = pc;
  assign out.inst  = inst;

  assign mem_r.arvalid = ~reset & (state == ST_REQ);
  assign mem_r.araddr  = pc;
  assign mem_r.arid    = '0;
  assign mem_r.arlen   = LEN_SINGLE;
  assign mem_r.arsize  = SIZE_4B;
  assign mem_r.arburst = BURST_FIXED;
  assign mem_r.rready  = (state == ST_RESP);

endmodule

// File: src/imem_axi.sv
`timescale 1ns/1ns

module imem_axi #(
  parameter int mem_words = 256
) (
  input  logic                       clock,
  input  logic                       reset,
  axi_if.slave                       mem_r,
  input  logic                       load_en,
  input  logic [31:0]                load_addr, // word index
  input  logic [axi_pkg::DATA_W-1:0] load_data
);
  import axi_pkg::*;

  localparam int idx_w = (mem_words > 1) ? $clog2(mem_words) : 1;

  logic [DATA_W-1:0] mem [mem_words];
  logic              pending;
  logic [DATA_W-1:0] rdata_q;
  logic [idx_w-1:0]  rd_idx;
  logic [idx_w-1:0]  wr_idx;
  logic              req_ok;
  logic              ar_fire;
  logic              r_fire;

  assign rd_idx  = mem_r.araddr[3 +: idx_w]; // byte address to 64-bit word
  assign wr_idx  = load_addr[idx_w-1:0];
  assign ar_fire = mem_r.arvalid & mem_r.arready;
  assign r_fire  = mem_r.rvalid & mem_r.rready;

  // single master, id 0, single beat of 4 bytes
  assign req_ok = (mem_r.arid == '0) && (mem_r.arlen == LEN_SINGLE) &&
                  (mem_r.arsize == SIZE_4B) && (mem_r.arburst == BURST_FIXED);

  always_ff @(posedge clock) begin
    if (reset) begin
      pending <= 1'b0;
    end else if (ar_fire) begin
      pending <= 1'b1;
    end else if (r_fire) begin
      pending <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (ar_fire) begin
      rdata_q <= req_ok ? mem[rd_idx] : '0; // unsupported request reads zero
    end
  end

  always_ff @(posedge clock) begin
    if (load_en && !pending) begin
      mem[wr_idx] <= load_data;
    end
  end

  assign mem_r.arready = ~pending;
  assign mem_r.rvalid  = pending;
  assign mem_r.rdata   = rdata_q;
  assign mem_r.rlast   = pending; // always one beat

endmodule

// File: src/fetch_queue.sv
`timescale 1ns/1ns

module fetch_queue #(
  parameter int queue_depth = 4
) (
  input  logic    clock,
  input  logic    reset,
  input  logic    flush,
  fetch_if.sink   in,
  fetch_if.source out
);

  localparam int ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;

  logic [31:0]    pc_mem   [queue_depth];
  logic [31:0]    inst_mem [queue_depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w:0]   count;
  logic             push;
  logic             pop;

  assign push = in.valid & in.ready;
  assign pop  = out.valid & out.ready;

  always_ff @(posedge clock) begin
    if (reset || flush) begin // flush drops everything, incl. a push this cycle
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      pc_mem[wr_ptr]   <= in.pc;
      inst_mem[wr_ptr] <= in.inst;
    end
  end

  assign in.ready  = (count != (ptr_w + 1)'(queue_depth));
  assign out.valid = (count != '0);
  assign out.pc    = pc_mem[rd_ptr];
  assign out.inst  = inst_mem[rd_ptr];

endmodule

// File: src/predecode_redirect.sv
`timescale 1ns/1ns

module predecode_redirect (
  fetch_if.sink       in,
  input  logic        out_ready,
  output logic        out_valid,
  output logic [31:0] out_pc,
  output logic [31:0] out_inst,
  output logic        flush,
  output logic [31:0] dnpc
);
  import rv_inst_pkg::*;

  inst_t       word;
  logic        is_jal;
  logic        is_branch;
  logic        taken;
  logic        fire;
  logic [31:0] offset;

  assign word = in.inst;

  // jal read through the J view, branches through the B view
  assign is_jal    = (word.jtype.opcode == OP_JAL);
  assign is_branch = (word.btype.opcode == OP_BRANCH);

  // backward branches taken, forward ones fall through
  assign taken  = is_jal | (is_branch & word.btype.imm12);
  assign offset = is_jal ? imm_j(word) : imm_b(word);

  assign fire = in.valid & out_ready;

  // stream passes straight through
  assign out_valid = in.valid;
  assign out_pc    = in.pc;
  assign out_inst  = in.inst;
  assign in.ready  = out_ready;

  assign flush = fire & taken; // one pulse per handed-out redirect
  assign dnpc  = in.pc + offset;

endmodule

// File: src/fetch_top.sv
`timescale 1ns/1ns

module fetch_top #(
  parameter logic [axi_pkg::ADDR_W-1:0] reset_pc    = 32'h8000_0000,
  parameter int                         mem_words   = 256,
  parameter int                         queue_depth = 4
) (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       load_en,
  input  logic [31:0]                load_addr,
  input  logic [axi_pkg::DATA_W-1:0] load_data,
  input  logic                       out_ready,
  output logic                       out_valid,
  output logic [31:0]                out_pc,
  output logic [31:0]                out_inst
);

  logic        flush;
  logic [31:0] dnpc;

  axi_if   bus ();
  fetch_if fq_in ();
  fetch_if fq_out ();

  fetch_unit #(.reset_pc(reset_pc)) fetch_unit_inst (
    .clock (clock),
    .reset (reset),
    .flush (flush),
    .dnpc  (dnpc),
    .mem_r (bus.master),
    .out   (fq_in.source)
  );

  imem_axi #(.mem_words(mem_words)) imem_axi_inst (
    .clock     (clock),
    .reset     (reset),
    .mem_r     (bus.slave),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data)
  );

  fetch_queue #(.queue_depth(queue_depth)) fetch_queue_inst (
    .clock (clock),
    .reset (reset),
    .flush (flush),
    .in    (fq_in.sink),
    .out   (fq_out.source)
  );

  predecode_redirect predecode_redirect_inst (
    .in        (fq_out.sink),
    .out_ready (out_ready),
    .out_valid (out_valid),
    .out_pc    (out_pc),
    .out_inst  (out_inst),
    .flush     (flush),
    .dnpc      (dnpc)
  );

endmodule

// File: sim/fetch_tb.sv
`timescale 1ns/1ns

module fetch_tb;

  localparam logic [31:0] start_pc       = 32'h8000_0000;
  localparam int          num_slots      = 16; // instructions in the program
  localparam int          num_words      = num_slots / 2;
  localparam int          num_exp        = 24;
  localparam int          timeout_cycles = 200;
  localparam int          k_alu          = 0;
  localparam int          k_jal          = 1;
  localparam int          k_branch       = 2;

  logic        clock;
  logic        reset;
  logic        load_en;
  logic [31:0] load_addr;
  logic [63:0] load_data;
  logic        out_ready;
  logic        out_valid;
  logic [31:0] out_pc;
  logic [31:0] out_inst;

  integer seed = 32'ha8dc_1ecd;
  int     errors;
  int     checks;
  bit     aborted;

  // program table with one row per instruction slot
  int          slot_kind [num_slots];
  int          slot_off  [num_slots];
  logic [31:0] slot_word [num_slots];

  // expected output sequence
  logic [31:0] exp_pc   [num_exp];
  logic [31:0] exp_inst [num_exp];
  string       exp_name [num_exp];

  fetch_top #(
    .reset_pc    (start_pc),
    .mem_words   (256),
    .queue_depth (4)
  ) fetch_top_inst (
    .clock     (clock),
    .reset     (reset),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .out_ready (out_ready),
    .out_valid (out_valid),
    .out_pc    (out_pc),
    .out_inst  (out_inst)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  function automatic logic [31:0] enc_addi(input int n);
    return {n[11:0], 5'd0, 3'b000, n[4:0], 7'b0010011}; // addi xn, x0, n
  endfunction

  function automatic logic [31:0] enc_jal(input int off);
    logic [20:0] imm;
    imm = off[20:0];
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd0, 7'b1101111};
  endfunction

  function automatic logic [31:0] enc_branch(input logic [2:0] f3, input logic [4:0] rs1,
                                             input logic [4:0] rs2, input int off);
    logic [12:0] imm;
    imm = off[12:0];
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  task automatic set_slot(input int s, input int kind, input int off, input logic [31:0] w);
    slot_kind[s] = kind;
    slot_off[s]  = off;
    slot_word[s] = w;
  endtask

  task automatic build_program;
    for (int s = 0; s < num_slots; s++) begin
      set_slot(s, k_alu, 0, enc_addi(s + 1)); // distinct filler per slot
    end
    set_slot(2, k_branch, 8, enc_branch(3'b000, 5'd0, 5'd0, 8)); // beq forward
    set_slot(4, k_jal, 20, enc_jal(20));                           // 0x10 to 0x24
    set_slot(6, k_jal, 20, enc_jal(20));                           // 0x18 to 0x2c
    set_slot(9, k_branch, -12, enc_branch(3'b100, 5'd1, 5'd2, -12)); // blt back to 0x18
    set_slot(12, k_jal, -48, enc_jal(-48));                        // loop to start
  endtask

  // reference model where jal and backward branches redirect and all else goes to pc+4
  task automatic build_expected;
    int    off;
    int    s;
    string name;
    off  = 0;
    name = "reset_start";
    for (int i = 0; i < num_exp; i++) begin
      s           = off / 4;
      exp_pc[i]   = start_pc + off;
      exp_inst[i] = slot_word[s];
      exp_name[i] = name;
      if (slot_kind[s] == k_jal) begin
        off  = off + slot_off[s];
        name = "jal_redirect";
      end else if (slot_kind[s] == k_branch && slot_off[s] < 0) begin
        off  = off + slot_off[s];
        name = "branch_taken";
      end else if (slot_kind[s] == k_branch) begin
        off  = off + 4;
        name = "branch_fallthrough";
      end else begin
        off  = off + 4;
        name = "sequential";
      end
    end
  endtask

  // 10 cycles of reset with memory rows written from the second cycle on
  task automatic do_reset(input bit load);
    reset     = 1'b1;
    out_ready = 1'b0;
    for (int i = 0; i < 10; i++) begin
      if (load && i >= 1 && i <= num_words) begin
        load_en   = 1'b1;
        load_addr = i - 1;
        load_data = {slot_word[2*i-1], slot_word[2*i-2]}; // upper half is pc+4
      end else begin
        load_en = 1'b0;
      end
      @(negedge clock);
      if (out_valid !== 1'b0) begin
        errors++;
        $display("[FAIL] reset_quiet #%0d out_valid: expected 0, actual %b", i, out_valid);
      end
    end
    load_en = 1'b0;
    reset   = 1'b0;
  endtask

  task automatic wait_output(input bit random_ready, output bit got,
                             output logic [31:0] pc, output logic [31:0] inst);
    int          cycles;
    logic [31:0] rnd;
    got    = 1'b0;
    cycles = 0;
    pc     = '0;
    inst   = '0;
    while (!got && cycles < timeout_cycles) begin
      @(negedge clock);
      rnd       = $random(seed);
      out_ready = random_ready ? (rnd[2:0] == 3'b000) : 1'b1; // mostly low so the queue fills
      if (out_valid === 1'b1 && out_ready) begin // taken on the next rising edge
        got  = 1'b1;
        pc   = out_pc;
        inst = out_inst;
      end
      cycles++;
    end
  endtask

  task automatic check_value(input string name, input int n, input string field,
                             input logic [31:0] expected, input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %s #%0d %s: expected %h, actual %h", name, n, field, expected, actual);
    end
  endtask

  task automatic run_stream(input bit random_ready, input string phase);
    bit          got;
    logic [31:0] pc;
    logic [31:0] inst;
    for (int n = 0; n < num_exp && !aborted; n++) begin
      wait_output(random_ready, got, pc, inst);
      if (!got) begin
        errors++;
        aborted = 1'b1;
        $display("timeout: no output within %0d cycles in %s at entry %0d",
                 timeout_cycles, phase, n);
      end else begin
        check_value({phase, "/", exp_name[n]}, n, "pc", exp_pc[n], pc);
        check_value({phase, "/", exp_name[n]}, n, "inst", exp_inst[n], inst);
      end
    end
  endtask

  initial begin
    reset     = 1'b1;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    out_ready = 1'b0;
    errors    = 0;
    checks    = 0;
    aborted   = 1'b0;

    build_program;
    build_expected;

    do_reset(1'b1);
    run_stream(1'b0, "ready_high");

    // let the stream run on and then reset in the middle of it
    out_ready = 1'b1;
    repeat (7) @(negedge clock);
    do_reset(1'b0);
    run_stream(1'b1, "backpressure");

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: tb.f
src/axi_pkg.sv
src/rv_inst_pkg.sv
src/axi_if.sv
src/fetch_if.sv
src/fetch_unit.sv
src/imem_axi.sv
src/fetch_queue.sv
src/predecode_redirect.sv
src/fetch_top.sv
sim/fetch_tb.sv
